//--- logic/snes_pad_pkg.sv
package snes_pad_pkg;

    // *************************************************************************
    // Serial pad framing.
    // *************************************************************************

    // Clock pulses sent to the pads in one poll.
    localparam int pad_bits = 16;

    // Real buttons per pad; the trailing four bits are always high on the wire.
    localparam int button_bits = 12;

    // *************************************************************************
    // Host read channel.
    // *************************************************************************

    localparam int axil_data_width = 32;

    // Lowest bit of the pad 1 lane in the read word.
    localparam int pad1_lane_lsb = 16;

    // *************************************************************************
    // Poll sequencer phases.
    // *************************************************************************

    // Current phase of a poll.
    typedef enum logic [1:0] {
        idle  = 2'd0,
        latch = 2'd1,
        shift = 2'd2,
        gap   = 2'd3
    } poll_state_t;

endpackage

//--- logic/poll_sequencer.sv
`timescale 1ns/1ps

module poll_sequencer #(
    parameter int clk_div    = 4,
    parameter int gap_cycles = 20
) (
    input  logic clk,
    input  logic aresetn,
    output logic pad_latch,
    output logic pad_clk,
    output logic sample,
    output logic commit
);

    import snes_pad_pkg::*;

    localparam int period  = 2 * clk_div;
    localparam int cnt_max = (period > gap_cycles) ? period : gap_cycles;
    localparam int cnt_w   = $clog2(cnt_max + 1);
    localparam int bit_w   = $clog2(pad_bits);

    poll_state_t      state;
    poll_state_t      state_nxt;
    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_nxt;
    logic [bit_w-1:0] bit_cnt;
    logic [bit_w-1:0] bit_nxt;

    // *************************************************************************
    // Phase and counter update.
    // *************************************************************************

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt + 1'b1;
        bit_nxt   = bit_cnt;
        case (state)
            idle: begin
                state_nxt = latch;
                cnt_nxt   = '0;
                bit_nxt   = '0;
            end
            latch: begin
                if (cnt == cnt_w'(period - 1)) begin
                    state_nxt = shift;
                    cnt_nxt   = '0;
                end
            end
            shift: begin
                // One bit period ends here.
                if (cnt == cnt_w'(period - 1)) begin
                    cnt_nxt = '0;
                    if (bit_cnt == bit_w'(pad_bits - 1)) begin
                        state_nxt = gap;
                    end else begin
                        bit_nxt = bit_cnt + 1'b1;
                    end
                end
            end
            gap: begin
                if (cnt == cnt_w'(gap_cycles - 1)) begin
                    state_nxt = idle;
                    cnt_nxt   = '0;
                end
            end
            default: begin
                state_nxt = idle;
                cnt_nxt   = '0;
            end
        endcase
    end

    // Outputs are registered from the next phase so they line up with state.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state     <= idle;
            cnt       <= '0;
            bit_cnt   <= '0;
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
            sample    <= 1'b0;
            commit    <= 1'b0;
        end else begin
            state     <= state_nxt;
            cnt       <= cnt_nxt;
            bit_cnt   <= bit_nxt;
            pad_latch <= (state_nxt == latch);
            pad_clk   <= (state_nxt == shift) && (cnt_nxt >= cnt_w'(clk_div));
            // Last low cycle of the bit period.
            sample    <= (state_nxt == shift) && (cnt_nxt == cnt_w'(clk_div - 1));
            commit    <= (state_nxt == shift) && (bit_nxt == bit_w'(pad_bits - 1))
                         && (cnt_nxt == cnt_w'(clk_div));
        end
    end

    latch_clk_exclusive: assert property (
        @(posedge clk) disable iff (!aresetn) !(pad_latch && pad_clk)
    ) else $error("pad_latch and pad_clk high together");

    // Commit follows the 16th sample by exactly one cycle.
    commit_after_last_sample: assert property (
        @(posedge clk) disable iff (!aresetn)
        commit |-> (state == shift) && (bit_cnt == bit_w'(pad_bits - 1)) && $past(sample)
    ) else $error("commit outside the last bit period");

endmodule

//--- logic/pad_shift_receiver.sv
`timescale 1ns/1ps

module pad_shift_receiver (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic                                pad_data,
    input  logic                                sample,
    output logic [snes_pad_pkg::button_bits-1:0] word
);

    import snes_pad_pkg::*;

    logic [pad_bits-1:0] shift_reg;

    // *************************************************************************
    // Serial capture.
    // *************************************************************************

    // Pad data is active low.
    // New bits enter at the top, so the first bit sent lands in bit 0
    // once all sixteen have been taken.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            shift_reg <= '0;
        end else if (sample) begin
            shift_reg <= {~pad_data, shift_reg[pad_bits-1:1]};
        end
    end

    // Trailing bits 15..12 carry no buttons.
    assign word = shift_reg[button_bits-1:0];

endmodule

//--- logic/button_accumulator.sv
`timescale 1ns/1ps

module button_accumulator (
    input  logic                                clk,
    input  logic                                aresetn,
    input  logic [snes_pad_pkg::button_bits-1:0] word,
    input  logic                                commit,
    input  logic                                read_done,
    output logic [snes_pad_pkg::button_bits-1:0] held_buttons
);

    // *************************************************************************
    // Sticky press record.
    // *************************************************************************

    // A button seen in any poll stays set until the host reads it.
    // The read clears old presses, but a word committed in the same cycle
    // is kept so that press is not lost.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            held_buttons <= '0;
        end else if (read_done) begin
            if (commit) begin
                held_buttons <= word;
            end else begin
                held_buttons <= '0;
            end
        end else if (commit) begin
            held_buttons <= held_buttons | word;
        end
    end

endmodule

//--- logic/axil_read_port.sv
`timescale 1ns/1ps

module axil_read_port (
    input  logic                                    clk,
    input  logic                                    aresetn,
    input  logic [snes_pad_pkg::button_bits-1:0]     pad0_buttons,
    input  logic [snes_pad_pkg::button_bits-1:0]     pad1_buttons,
    output logic [snes_pad_pkg::axil_data_width-1:0] s_axil_rdata,
    output logic [1:0]                              s_axil_rresp,
    output logic                                    s_axil_rvalid,
    input  logic                                    s_axil_rready,
    output logic                                    read_done
);

    import snes_pad_pkg::*;

    localparam logic [1:0] resp_okay = 2'b00;

    logic [axil_data_width-1:0] rdata_nxt;

    // Pad 0 in the low lane, pad 1 in the upper lane, rest zero.
    always_comb begin
        rdata_nxt                                = '0;
        rdata_nxt[button_bits-1:0]               = pad0_buttons;
        rdata_nxt[pad1_lane_lsb +: button_bits]  = pad1_buttons;
    end

    // *************************************************************************
    // Read data channel.
    // *************************************************************************

    // A status word is always on offer once out of reset.
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            s_axil_rvalid <= 1'b0;
            s_axil_rdata  <= '0;
        end else begin
            s_axil_rvalid <= 1'b1;
            // Word only moves when the channel is empty or being taken.
            if (!s_axil_rvalid || s_axil_rready) begin
                s_axil_rdata <= rdata_nxt;
            end
        end
    end

    assign s_axil_rresp = resp_okay;
    assign read_done    = s_axil_rvalid && s_axil_rready;

    rdata_held_while_stalled: assert property (
        @(posedge clk) disable iff (!aresetn)
        (s_axil_rvalid && !s_axil_rready) |=> $stable(s_axil_rdata)
    ) else $error("s_axil_rdata changed while waiting for rready");

endmodule

//--- logic/snes_pad_reader.sv
`timescale 1ns/1ps

module snes_pad_reader #(
    parameter int clk_div    = 4,
    parameter int gap_cycles = 20
) (
    input  logic                                    clk,
    input  logic                                    aresetn,

    output logic                                    pad_latch,
    output logic                                    pad_clk,
    input  logic                                    pad0_data,
    input  logic                                    pad1_data,

    output logic [snes_pad_pkg::axil_data_width-1:0] s_axil_rdata,
    output logic [1:0]                              s_axil_rresp,
    output logic                                    s_axil_rvalid,
    input  logic                                    s_axil_rready
);

    import snes_pad_pkg::*;

    logic                   sample;
    logic                   commit;
    logic                   read_done;
    logic [button_bits-1:0] pad0_word;
    logic [button_bits-1:0] pad1_word;
    logic [button_bits-1:0] pad0_held;
    logic [button_bits-1:0] pad1_held;

    // *************************************************************************
    // Poll timing shared by both pads.
    // *************************************************************************

    poll_sequencer #(
        .clk_div    (clk_div),
        .gap_cycles (gap_cycles)
    ) u_poll_sequencer (
        .clk       (clk),
        .aresetn   (aresetn),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .sample    (sample),
        .commit    (commit)
    );

    pad_shift_receiver u_pad0_receiver (
        .clk      (clk),
        .aresetn  (aresetn),
        .pad_data (pad0_data),
        .sample   (sample),
        .word     (pad0_word)
    );

    pad_shift_receiver u_pad1_receiver (
        .clk      (clk),
        .aresetn  (aresetn),
        .pad_data (pad1_data),
        .sample   (sample),
        .word     (pad1_word)
    );

    button_accumulator u_pad0_accumulator (
        .clk          (clk),
        .aresetn      (aresetn),
        .word         (pad0_word),
        .commit       (commit),
        .read_done    (read_done),
        .held_buttons (pad0_held)
    );

    button_accumulator u_pad1_accumulator (
        .clk          (clk),
        .aresetn      (aresetn),
        .word         (pad1_word),
        .commit       (commit),
        .read_done    (read_done),
        .held_buttons (pad1_held)
    );

    // *************************************************************************
    // Host side.
    // *************************************************************************

    axil_read_port u_axil_read_port (
        .clk           (clk),
        .aresetn       (aresetn),
        .pad0_buttons  (pad0_held),
        .pad1_buttons  (pad1_held),
        .s_axil_rdata  (s_axil_rdata),
        .s_axil_rresp  (s_axil_rresp),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready),
        .read_done     (read_done)
    );

endmodule

//--- verif/pad_model.sv
`timescale 1ns/1ps

module pad_model (
    input  logic                              pad_latch,
    input  logic                              pad_clk,
    input  logic [snes_pad_pkg::pad_bits-1:0] load_word,
    output logic                              pad_data
);

    import snes_pad_pkg::*;

    logic [pad_bits-1:0] shift_word;

    // *************************************************************************
    // Serial pad behavior.
    // *************************************************************************

    // Line idles high, no button pressed.
    initial begin
        shift_word = '1;
    end

    // The word is taken on the latch rise and bit 0 shows at once.
    // Every pad clock rise moves on one bit, ones fill in from the top,
    // so the line reads high after all sixteen bits.
    always @(posedge pad_latch or posedge pad_clk) begin
        if (pad_latch) begin
            shift_word <= load_word;
        end else begin
            shift_word <= {1'b1, shift_word[pad_bits-1:1]};
        end
    end

    assign pad_data = shift_word[0];

endmodule

//--- verif/pad_reader_tb.sv
`timescale 1ns/1ps

module pad_reader_tb;

    import snes_pad_pkg::*;

    localparam int clk_div        = 2;
    localparam int gap_cycles     = 10;
    localparam int poll_cycles    = 2 * clk_div * (pad_bits + 1) + 1 + gap_cycles;
    localparam int num_polls      = 40;
    localparam int timeout_cycles = num_polls * poll_cycles + 200;

    // Bits 31..28 and 15..12 carry no buttons.
    localparam logic [31:0] unused_mask = 32'hF000_F000;

    logic                       clk = 1'b0;
    logic                       aresetn;
    logic                       pad_latch;
    logic                       pad_clk;
    logic                       pad0_data;
    logic                       pad1_data;
    logic [axil_data_width-1:0] s_axil_rdata;
    logic [1:0]                 s_axil_rresp;
    logic                       s_axil_rvalid;
    logic                       s_axil_rready;

    integer              seed;
    logic [31:0]         rnd;
    logic [pad_bits-1:0] pad0_next;
    logic [pad_bits-1:0] pad1_next;
    logic [pad_bits-1:0] pad0_cur;
    logic [pad_bits-1:0] pad1_cur;

    // Reference model state.
    logic                   model_on = 1'b0;
    logic [button_bits-1:0] m_acc0;
    logic [button_bits-1:0] m_acc1;
    logic [31:0]            m_rdata;
    logic                   m_rvalid;
    logic                   prev_latch;
    logic                   prev_clk;
    int                     poll_cycle;
    int                     cycles_out;
    int                     clk_rises;
    int                     latch_high;
    int                     clk_high;
    int                     polls_seen;
    int                     commits;
    int                     transfers;
    int                     overlap_hits;
    int                     cycle_count = 0;

    snes_pad_reader #(
        .clk_div    (clk_div),
        .gap_cycles (gap_cycles)
    ) u_snes_pad_reader (
        .clk           (clk),
        .aresetn       (aresetn),
        .pad_latch     (pad_latch),
        .pad_clk       (pad_clk),
        .pad0_data     (pad0_data),
        .pad1_data     (pad1_data),
        .s_axil_rdata  (s_axil_rdata),
        .s_axil_rresp  (s_axil_rresp),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready)
    );

    pad_model u_pad0_model (
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .load_word (pad0_next),
        .pad_data  (pad0_data)
    );

    pad_model u_pad1_model (
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .load_word (pad1_next),
        .pad_data  (pad1_data)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Errors found");
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_commits(input int count);
        while (commits < count) begin
            next_cycle();
        end
    endtask

    // *************************************************************************
    // Reference model sampled mid-cycle.
    // *************************************************************************

    always @(negedge clk) begin : reference_model
        logic                   read_done;
        logic                   commit_now;
        logic [button_bits-1:0] word0;
        logic [button_bits-1:0] word1;
        read_done  = 1'b0;
        commit_now = 1'b0;
        if (model_on) begin
            check_value("s_axil_rvalid", 32'(s_axil_rvalid), 32'(m_rvalid));
            check_value("s_axil_rdata_unused", s_axil_rdata & unused_mask, 32'd0);
            check_value("s_axil_rdata", s_axil_rdata, m_rdata);
            check_value("s_axil_rresp", 32'(s_axil_rresp), 32'd0);
        end
        if (!aresetn) begin
            if (model_on) begin
                check_value("pad_latch", 32'(pad_latch), 32'd0);
                check_value("pad_clk", 32'(pad_clk), 32'd0);
            end
            m_acc0       = '0;
            m_acc1       = '0;
            m_rdata      = '0;
            m_rvalid     = 1'b0;
            prev_latch   = 1'b0;
            prev_clk     = 1'b0;
            poll_cycle   = 0;
            cycles_out   = 0;
            clk_rises    = 0;
            latch_high   = 0;
            clk_high     = 0;
            polls_seen   = 0;
            commits      = 0;
            transfers    = 0;
            overlap_hits = 0;
            model_on     = 1'b1;
        end else begin
            check_value("pad_latch_and_pad_clk", 32'(pad_latch & pad_clk), 32'd0);

            // Latch pulse and poll length.
            if (pad_latch && !prev_latch) begin
                if (polls_seen == 0) begin
                    check_value("first_latch_cycle", cycles_out, 32'd1);
                end else begin
                    check_value("poll_length", poll_cycle, poll_cycles);
                    check_value("pad_clk_rises", clk_rises, pad_bits);
                end
                polls_seen++;
                poll_cycle = 0;
                clk_rises  = 0;
                latch_high = 0;
                pad0_cur   = pad0_next;
                pad1_cur   = pad1_next;
                rnd        = $random(seed);
                pad0_next  = rnd[pad_bits-1:0];
                rnd        = $random(seed);
                pad1_next  = rnd[pad_bits-1:0];
            end
            if (pad_latch) begin
                latch_high++;
            end else if (prev_latch) begin
                check_value("latch_width", latch_high, 2 * clk_div);
            end

            // Pad clock periods; the 16th rise marks the commit cycle.
            if (pad_clk && !prev_clk) begin
                clk_rises++;
                clk_high = 0;
                check_value("pad_clk_rise_cycle", poll_cycle,
                            2 * clk_div * clk_rises + clk_div);
                if (clk_rises == pad_bits) begin
                    commit_now = 1'b1;
                end
            end
            if (pad_clk) begin
                clk_high++;
            end else if (prev_clk) begin
                check_value("pad_clk_high_width", clk_high, clk_div);
            end

            // Read channel and sticky records.
            word0     = ~pad0_cur[button_bits-1:0];
            word1     = ~pad1_cur[button_bits-1:0];
            read_done = m_rvalid && s_axil_rready;
            if (read_done) begin
                transfers++;
                if (commit_now) begin
                    overlap_hits++;
                end
            end
            if (commit_now) begin
                commits++;
            end
            if (!m_rvalid || s_axil_rready) begin
                m_rdata = {4'b0, m_acc1, 4'b0, m_acc0};
            end
            if (read_done) begin
                m_acc0 = commit_now ? word0 : '0;
                m_acc1 = commit_now ? word1 : '0;
            end else if (commit_now) begin
                m_acc0 = m_acc0 | word0;
                m_acc1 = m_acc1 | word1;
            end
            m_rvalid = 1'b1;

            poll_cycle++;
            cycles_out++;
            prev_latch = pad_latch;
            prev_clk   = pad_clk;
        end
    end

    always @(posedge clk) begin : timeout_watch
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Errors found");
            $fatal(1, "Timeout: the polls did not finish within %0d cycles", timeout_cycles);
        end
    end

    // *************************************************************************
    // Stimulus.
    // *************************************************************************

    initial begin : stimulus
        seed          = 48;
        aresetn       = 1'b0;
        s_axil_rready = 1'b0;
        rnd           = $random(seed);
        pad0_next     = rnd[pad_bits-1:0];
        rnd           = $random(seed);
        pad1_next     = rnd[pad_bits-1:0];
        pad0_cur      = '1;
        pad1_cur      = '1;

        repeat (16) @(posedge clk);
        #2;
        aresetn = 1'b1;

        // Host stalls across several polls.
        wait_commits(4);
        repeat (3) next_cycle();
        s_axil_rready = 1'b1;
        repeat (2) next_cycle();
        s_axil_rready = 1'b0;

        // Ready held through whole polls, so commits meet handshakes.
        wait_commits(5);
        next_cycle();
        s_axil_rready = 1'b1;
        wait_commits(7);
        next_cycle();

        // Random back-pressure for the rest.
        while (commits < num_polls) begin
            rnd           = $random(seed);
            s_axil_rready = rnd[0];
            next_cycle();
        end
        s_axil_rready = 1'b1;
        repeat (4) next_cycle();

        if (overlap_hits > 0 && transfers > 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "No read handshake fell on a commit cycle, or no word was read");
        end
    end

endmodule

//--- src.f
logic/snes_pad_pkg.sv
logic/poll_sequencer.sv
logic/pad_shift_receiver.sv
logic/button_accumulator.sv
logic/axil_read_port.sv
logic/snes_pad_reader.sv
verif/pad_model.sv
verif/pad_reader_tb.sv

//--- run.sh
#!/bin/sh
# Builds the pad reader testbench with Verilator and runs it.
# The exit status of the model is the result of the run.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module pad_reader_tb \
    -Mdir obj_dir

./obj_dir/Vpad_reader_tb
